// File: hw/excp_pkg.sv
// exception tags carried by every fetch entry
package excp_pkg;

    // width of one cause code
    localparam int ecode_w = 6;

    // number of exception sources tagged at fetch
    localparam int excp_w = 2;

    // bit positions inside is_exception / exception_cause
    localparam int excp_adef_bit = 0;
    localparam int excp_int_bit  = 1;

    ////////////////////////////////////////////////////////////////////
    // cause codes
    ////////////////////////////////////////////////////////////////////

    // no exception in this slot
    localparam logic [ecode_w-1:0] exception_nop  = 6'h3f;
    // interrupt taken at this entry
    localparam logic [ecode_w-1:0] exception_int  = 6'h00;
    // fetch address not word aligned
    localparam logic [ecode_w-1:0] exception_adef = 6'h08;

endpackage

// File: hw/frontend_pkg.sv
// buses shared by the fetch front end
package frontend_pkg;

    ////////////////////////////////////////////////////////////////////
    // control from fetch_ctrl
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic pause;
        logic exception_flush;
        logic branch_flush;
    } ctrl_t;

    // exception entry target plus interrupt marker
    typedef struct packed {
        logic [31:0] exception_new_pc;
        logic        is_interrupt;
    } ctrl_pc_t;

    ////////////////////////////////////////////////////////////////////
    // branch resolution and prediction
    ////////////////////////////////////////////////////////////////////

    // verdict from the back end, one branch per cycle
    typedef struct packed {
        logic        valid;
        logic        mispredict;
        logic [31:0] branch_pc;
        logic [31:0] actual_target;
        logic        taken;
    } resolve_t;

    // btb lookup result for the current pc
    typedef struct packed {
        logic        hit_taken;
        logic [31:0] target;
    } pred_t;

    ////////////////////////////////////////////////////////////////////
    // queue entry
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0]                                          pc;
        logic                                                 pred_taken;
        logic [31:0]                                          pred_target;
        logic [excp_pkg::excp_w-1:0]                          is_exception;
        logic [excp_pkg::excp_w-1:0][excp_pkg::ecode_w-1:0]   exception_cause;
        logic                                                 uncache;
    } fetch_entry_t;

endpackage

// File: hw/fetch_ctrl.sv
module fetch_ctrl (
    input  logic                   clk,
    input  logic                   rst,

    // back end requests
    input  frontend_pkg::resolve_t resolve,
    input  logic                   excp_req,
    input  logic [31:0]            excp_new_pc,
    input  logic                   intr_pending,

    // back-pressure from the queue
    input  logic                   queue_full,

    output frontend_pkg::ctrl_t    ctrl,
    output frontend_pkg::ctrl_pc_t ctrl_pc
);

    logic is_int;
    logic mispredict;

    ////////////////////////////////////////////////////////////////////
    // redirect ranking
    ////////////////////////////////////////////////////////////////////

    assign mispredict = resolve.valid && resolve.mispredict;

    // exception entry beats everything
    assign ctrl.exception_flush = excp_req;
    // branch redirect only when no exception this cycle
    assign ctrl.branch_flush = mispredict && !excp_req;
    // full queue stalls the pc, but a flush empties it anyway
    assign ctrl.pause = queue_full && !excp_req && !mispredict;

    ////////////////////////////////////////////////////////////////////
    // interrupt marker
    ////////////////////////////////////////////////////////////////////

    // captured with the exception request to tag the redirected entry
    // dropped once that entry has been pushed (first unpaused edge)
    always_ff @(posedge clk) begin
        if (rst) begin
            is_int <= 1'b0;
        end else if (excp_req) begin
            is_int <= intr_pending;
        end else if (!ctrl.pause) begin
            is_int <= 1'b0;
        end
    end

    assign ctrl_pc.exception_new_pc = excp_new_pc;
    assign ctrl_pc.is_interrupt     = is_int;

    // a stall must never hide a redirect
    a_no_pause_on_flush: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.pause && (ctrl.exception_flush || ctrl.branch_flush))
    );

endmodule

// File: hw/pc_reg.sv
module pc_reg #(
    parameter logic [31:0] reset_pc       = 32'h0000_0000,
    parameter logic [31:0] uncached_limit = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       rst,

    input  frontend_pkg::ctrl_t        ctrl,
    input  frontend_pkg::ctrl_pc_t     ctrl_pc,

    // real target of a mispredicted branch
    input  logic [31:0]                branch_actual_addr,

    // btb prediction for the current pc
    input  frontend_pkg::pred_t        pred,

    output frontend_pkg::fetch_entry_t entry
);

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic        addr_err;

    ////////////////////////////////////////////////////////////////////
    // next fetch address
    ////////////////////////////////////////////////////////////////////

    // priority: exception, pause, branch redirect, prediction, +4
    always_comb begin
        if (ctrl.exception_flush) begin
            pc_next = ctrl_pc.exception_new_pc;
        end else if (ctrl.pause) begin
            pc_next = pc;
        end else if (ctrl.branch_flush) begin
            pc_next = branch_actual_addr;
        end else if (pred.hit_taken) begin
            // follow the predicted target
            pc_next = pred.target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // entry tagging, all on the current pc
    ////////////////////////////////////////////////////////////////////

    // word fetch only
    assign addr_err = (pc[1:0] != 2'b00);

    always_comb begin
        entry.pc          = pc;
        entry.pred_taken  = pred.hit_taken;
        entry.pred_target = pred.target;

        entry.is_exception[excp_pkg::excp_int_bit]  = ctrl_pc.is_interrupt;
        entry.is_exception[excp_pkg::excp_adef_bit] = addr_err;

        entry.exception_cause[excp_pkg::excp_int_bit] =
            ctrl_pc.is_interrupt ? excp_pkg::exception_int : excp_pkg::exception_nop;
        entry.exception_cause[excp_pkg::excp_adef_bit] =
            addr_err ? excp_pkg::exception_adef : excp_pkg::exception_nop;

        // low region bypasses the cache
        entry.uncache = (pc < uncached_limit);
    end

    // queue back-pressure freezes the fetch address
    a_pause_holds_pc: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.pause |=> $stable(pc)
    );

endmodule

// File: hw/btb.sv
module btb #(
    parameter int btb_idx_w = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // lookup side, combinational
    input  logic [31:0]            lookup_pc,
    output frontend_pkg::pred_t    pred,

    // training from the back end
    input  frontend_pkg::resolve_t resolve
);

    localparam int depth = 1 << btb_idx_w;
    // bits above index and the two byte-offset bits
    localparam int tag_w = 30 - btb_idx_w;

    // table storage
    logic [tag_w-1:0] tag_mem    [depth];
    logic [31:0]      target_mem [depth];
    logic [1:0]       cnt_mem    [depth];
    logic [depth-1:0] valid_q;

    logic [btb_idx_w-1:0] lk_idx;
    logic [tag_w-1:0]     lk_tag;
    logic                 lk_hit;

    logic [btb_idx_w-1:0] up_idx;
    logic [tag_w-1:0]     up_tag;
    logic                 up_hit;

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    assign lk_idx = lookup_pc[btb_idx_w+1:2];
    assign lk_tag = lookup_pc[31:btb_idx_w+2];
    assign lk_hit = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    // counter msb set means weakly or strongly taken
    assign pred.hit_taken = lk_hit && cnt_mem[lk_idx][1];
    assign pred.target    = target_mem[lk_idx];

    ////////////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////////////

    assign up_idx = resolve.branch_pc[btb_idx_w+1:2];
    assign up_tag = resolve.branch_pc[31:btb_idx_w+2];
    assign up_hit = valid_q[up_idx] && (tag_mem[up_idx] == up_tag);

    // valid bits only, table contents are don't-care until allocated
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (resolve.valid && resolve.taken) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            if (resolve.taken) begin
                if (up_hit) begin
                    // strengthen, saturate at 3
                    if (cnt_mem[up_idx] != 2'd3) begin
                        cnt_mem[up_idx] <= cnt_mem[up_idx] + 2'd1;
                    end
                    target_mem[up_idx] <= resolve.actual_target;
                end else begin
                    // allocate, replaces whatever was there
                    tag_mem[up_idx]    <= up_tag;
                    target_mem[up_idx] <= resolve.actual_target;
                    cnt_mem[up_idx]    <= 2'd2;
                end
            end else if (up_hit) begin
                // weaken, saturate at 0
                if (cnt_mem[up_idx] != 2'd0) begin
                    cnt_mem[up_idx] <= cnt_mem[up_idx] - 2'd1;
                end
            end
        end
    end

endmodule

// File: hw/fetch_queue.sv
module fetch_queue #(
    parameter int queue_depth = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    input  frontend_pkg::ctrl_t        ctrl,
    input  frontend_pkg::fetch_entry_t push_entry,

    // decode side
    input  logic                       pop,
    output frontend_pkg::fetch_entry_t head,
    output logic                       empty,
    output logic                       full
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = ptr_w + 1;
    localparam logic [cnt_w-1:0] count_max = cnt_w'(queue_depth);

    frontend_pkg::fetch_entry_t mem [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic flush;
    logic push;
    logic pop_ok;

    assign flush  = ctrl.exception_flush || ctrl.branch_flush;
    // one entry per unpaused cycle
    assign push   = !ctrl.pause && !flush;
    // pop on empty is ignored
    assign pop_ok = pop && !empty;

    ////////////////////////////////////////////////////////////////////
    // pointers and fill level
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // wrong-path entries dropped
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop_ok);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (!rst && push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == count_max);

    // pause from fetch_ctrl must cover every full cycle
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    );

endmodule

// File: hw/frontend_top.sv
module frontend_top #(
    parameter logic [31:0] reset_pc       = 32'h1c00_0000,
    parameter logic [31:0] uncached_limit = 32'h1c00_0100,
    parameter int          btb_idx_w      = 4,
    parameter int          queue_depth    = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    // back end
    input  frontend_pkg::resolve_t     resolve,
    input  logic                       excp_req,
    input  logic [31:0]                excp_new_pc,
    input  logic                       intr_pending,

    // decode
    input  logic                       pop,
    output frontend_pkg::fetch_entry_t head,
    output logic                       empty
);

    frontend_pkg::ctrl_t        ctrl;
    frontend_pkg::ctrl_pc_t     ctrl_pc;
    frontend_pkg::pred_t        pred;
    frontend_pkg::fetch_entry_t cur_entry;
    logic                       queue_full;

    ////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////

    fetch_ctrl i_fetch_ctrl (
        .clk          (clk),
        .rst          (rst),
        .resolve      (resolve),
        .excp_req     (excp_req),
        .excp_new_pc  (excp_new_pc),
        .intr_pending (intr_pending),
        .queue_full   (queue_full),
        .ctrl         (ctrl),
        .ctrl_pc      (ctrl_pc)
    );

    ////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////

    pc_reg #(
        .reset_pc       (reset_pc),
        .uncached_limit (uncached_limit)
    ) i_pc_reg (
        .clk                (clk),
        .rst                (rst),
        .ctrl               (ctrl),
        .ctrl_pc            (ctrl_pc),
        .branch_actual_addr (resolve.actual_target),
        .pred               (pred),
        .entry              (cur_entry)
    );

    // predicts from the live pc
    btb #(
        .btb_idx_w (btb_idx_w)
    ) i_btb (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (cur_entry.pc),
        .pred      (pred),
        .resolve   (resolve)
    );

    fetch_queue #(
        .queue_depth (queue_depth)
    ) i_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .push_entry (cur_entry),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (queue_full)
    );

endmodule

// File: sim/frontend_tb.sv
module frontend_tb;

    localparam logic [31:0] reset_pc       = 32'h0000_0100;
    localparam logic [31:0] uncached_limit = 32'h0000_0120;
    localparam int          reset_cycles   = 16;
    // six tests, none longer than about 300 cycles, plus reset
    localparam int          watchdog_cycles = 2000;

    logic clk = 1'b0;
    logic rst;

    frontend_pkg::resolve_t     resolve;
    logic                       excp_req;
    logic [31:0]                excp_new_pc;
    logic                       intr_pending;
    logic                       pop;
    frontend_pkg::fetch_entry_t head;
    logic                       empty;

    int errors;
    int tests_failed;
    int test_start_errors;
    int unsigned seed_dummy;

    // reference model state
    logic [31:0] exp_pc;
    logic        exp_int;
    logic        btb_valid;
    logic [31:0] btb_pc;
    logic [31:0] btb_target;
    logic        exp_pred;
    logic        exp_adef;
    logic        popping;

    always #50 clk = ~clk;

    frontend_top #(
        .reset_pc       (reset_pc),
        .uncached_limit (uncached_limit),
        .btb_idx_w      (4),
        .queue_depth    (4)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .resolve      (resolve),
        .excp_req     (excp_req),
        .excp_new_pc  (excp_new_pc),
        .intr_pending (intr_pending),
        .pop          (pop),
        .head         (head),
        .empty        (empty)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    assign popping  = pop && !empty;
    // one trained branch, matched on the word address
    assign exp_pred = btb_valid && (exp_pc[31:2] == btb_pc[31:2]);
    assign exp_adef = (exp_pc[1:0] != 2'b00);

    always @(posedge clk) begin
        if (rst) begin
            exp_pc     <= reset_pc;
            exp_int    <= 1'b0;
            btb_valid  <= 1'b0;
            btb_pc     <= '0;
            btb_target <= '0;
        end else begin
            // exception over mispredict over the normal stream
            if (excp_req) begin
                exp_pc  <= excp_new_pc;
                exp_int <= intr_pending;
            end else if (resolve.valid && resolve.mispredict) begin
                exp_pc  <= resolve.actual_target;
                exp_int <= 1'b0;
            end else if (popping) begin
                exp_pc  <= exp_pred ? btb_target : exp_pc + 32'd4;
                exp_int <= 1'b0;
            end
            if (resolve.valid && resolve.taken) begin
                btb_valid  <= 1'b1;
                btb_pc     <= resolve.branch_pc;
                btb_target <= resolve.actual_target;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks on every honored pop
    //////////////////////////////////////////////////////////////////////

    a_head_pc: assert property (@(posedge clk) disable iff (rst)
        popping |-> head.pc == exp_pc)
        else begin
            errors++;
            $display("CHECK FAILED head.pc exp %08h got %08h", $sampled(exp_pc),
                     $sampled(head.pc));
        end

    a_uncache: assert property (@(posedge clk) disable iff (rst)
        popping |-> head.uncache == (exp_pc < uncached_limit))
        else begin
            errors++;
            $display("CHECK FAILED head.uncache exp %h got %h at pc %08h",
                     $sampled(exp_pc < uncached_limit), $sampled(head.uncache),
                     $sampled(exp_pc));
        end

    a_pred_taken: assert property (@(posedge clk) disable iff (rst)
        popping |-> head.pred_taken == exp_pred)
        else begin
            errors++;
            $display("CHECK FAILED head.pred_taken exp %h got %h", $sampled(exp_pred),
                     $sampled(head.pred_taken));
        end

    a_pred_target: assert property (@(posedge clk) disable iff (rst)
        popping && exp_pred |-> head.pred_target == btb_target)
        else begin
            errors++;
            $display("CHECK FAILED head.pred_target exp %08h got %08h",
                     $sampled(btb_target), $sampled(head.pred_target));
        end

    // address error tag and its cause code
    a_adef: assert property (@(posedge clk) disable iff (rst)
        popping |-> head.is_exception[excp_pkg::excp_adef_bit] == exp_adef &&
            head.exception_cause[excp_pkg::excp_adef_bit] ==
            (exp_adef ? excp_pkg::exception_adef : excp_pkg::exception_nop))
        else begin
            errors++;
            $display("CHECK FAILED head.adef exp %h got tag %h cause %h", $sampled(exp_adef),
                     $sampled(head.is_exception[excp_pkg::excp_adef_bit]),
                     $sampled(head.exception_cause[excp_pkg::excp_adef_bit]));
        end

    // interrupt tag only on the first entry after exception entry
    a_int: assert property (@(posedge clk) disable iff (rst)
        popping |-> head.is_exception[excp_pkg::excp_int_bit] == exp_int &&
            head.exception_cause[excp_pkg::excp_int_bit] ==
            (exp_int ? excp_pkg::exception_int : excp_pkg::exception_nop))
        else begin
            errors++;
            $display("CHECK FAILED head.int exp %h got tag %h cause %h", $sampled(exp_int),
                     $sampled(head.is_exception[excp_pkg::excp_int_bit]),
                     $sampled(head.exception_cause[excp_pkg::excp_int_bit]));
        end

    // any redirect drops the queued wrong-path entries
    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        excp_req || (resolve.valid && resolve.mispredict) |=> empty)
        else begin
            errors++;
            $display("CHECK FAILED empty exp %h got %h after flush", 1'b1, $sampled(empty));
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic frontend_pkg::resolve_t make_resolve(input logic mispredict,
        input logic [31:0] branch_pc, input logic [31:0] target, input logic taken);
        frontend_pkg::resolve_t r;
        r.valid         = 1'b1;
        r.mispredict    = mispredict;
        r.branch_pc     = branch_pc;
        r.actual_target = target;
        r.taken         = taken;
        return r;
    endfunction

    // n honored pops, up to max_gap idle cycles after each
    task automatic pop_entries(input int n, input int max_gap);
        int done_cnt;
        int gap;
        done_cnt = 0;
        gap = 0;
        while (done_cnt < n) begin
            // count the pop the coming edge will honor
            @(negedge clk);
            if (pop && !empty) begin
                done_cnt = done_cnt + 1;
            end
            @(posedge clk);
            if (done_cnt >= n) begin
                pop <= 1'b0;
            end else if (gap > 0) begin
                pop <= 1'b0;
                gap = gap - 1;
            end else begin
                pop <= 1'b1;
                gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            end
        end
    endtask

    task automatic wait_until_full(input int max_cycles);
        int n;
        n = 0;
        while (!i_dut.queue_full && n < max_cycles) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!i_dut.queue_full) begin
            errors++;
            $display("queue never became full while pop was held low");
        end
    endtask

    // mispredict, optionally with an exception request in the same cycle
    task automatic send_redirect(input logic [31:0] target, input logic excp,
        input logic [31:0] excp_pc, input logic intr);
        @(posedge clk);
        pop          <= 1'b0;
        resolve      <= make_resolve(1'b1, 32'h0000_0ff0, target, 1'b0);
        excp_req     <= excp;
        excp_new_pc  <= excp_pc;
        intr_pending <= intr;
        @(posedge clk);
        resolve      <= '0;
        excp_req     <= 1'b0;
        intr_pending <= 1'b0;
    endtask

    // correctly predicted taken branch, trains only
    task automatic train_branch(input logic [31:0] branch_pc, input logic [31:0] target);
        @(posedge clk);
        resolve <= make_resolve(1'b0, branch_pc, target, 1'b1);
        @(posedge clk);
        resolve <= '0;
    endtask

    task automatic end_test(input string name);
        // let the last edge's checks settle
        @(negedge clk);
        if (errors == test_start_errors) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed_dummy = $urandom(32'h2c4f);
        errors = 0;
        tests_failed = 0;
        test_start_errors = 0;
        rst = 1'b1;
        resolve = '0;
        excp_req = 1'b0;
        excp_new_pc = '0;
        intr_pending = 1'b0;
        pop = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // runs across the uncached limit
        pop_entries(12, 0);
        end_test("reset sequence");

        wait_until_full(20);
        pop_entries(16, 3);
        end_test("back-pressure");

        pop_entries(1, 0);
        send_redirect(32'h0000_0200, 1'b0, '0, 1'b0);
        pop_entries(6, 1);
        end_test("mispredict flush");

        send_redirect(32'h0000_03f0, 1'b1, 32'h0000_0280, 1'b1);
        pop_entries(5, 1);
        end_test("exception priority");

        train_branch(32'h0000_040c, 32'h0000_0500);
        send_redirect(32'h0000_0400, 1'b0, '0, 1'b0);
        pop_entries(8, 2);
        end_test("btb prediction");

        send_redirect(32'h0000_0602, 1'b0, '0, 1'b0);
        pop_entries(5, 1);
        end_test("misaligned redirect");

        $display("tests run 6, tests failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: compile.f
hw/excp_pkg.sv
hw/frontend_pkg.sv
hw/fetch_ctrl.sv
hw/pc_reg.sv
hw/btb.sv
hw/fetch_queue.sv
hw/frontend_top.sv
sim/frontend_tb.sv
